/* irq_arbiter.sv */
/*
  Samples the interrupt lines into the pending register and picks the winner.
  Priority is fixed: lines 31 down to 16, then 11, 3 and 7.
  The winner outputs are combinational from the pending register and mie_i.
*/

`include "irq_settings.svh"

module irq_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  irq_pkg::irq_vec_t irq_i,
  input  irq_pkg::irq_vec_t mie_i,
  output irq_pkg::irq_vec_t mip_o,
  output logic              any_enabled_o,
  output logic              win_valid_o,
  output irq_pkg::irq_id_t  win_id_o
);

  localparam irq_pkg::irq_vec_t VALID_MASK = `IRQ_VALID_MASK;

  irq_pkg::irq_vec_t pending_q;
  irq_pkg::irq_vec_t pend_en;

  // ------------------------------------------------
  // Pending register
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= irq_i & VALID_MASK;
    end
  end

  assign mip_o   = pending_q;
  assign pend_en = pending_q & mie_i;

  // Wakes the core even with the global enable cleared
  assign any_enabled_o = |pend_en;

  // ------------------------------------------------
  // Fixed-priority select
  // ------------------------------------------------
  // Later assignments override earlier ones, so the lowest rank is checked first
  always_comb begin
    win_valid_o = 1'b0;
    win_id_o    = '0;

    // Timer
    if (pend_en[7]) begin
      win_valid_o = 1'b1;
      win_id_o    = irq_pkg::irq_id_t'(7);
    end

    // Software
    if (pend_en[3]) begin
      win_valid_o = 1'b1;
      win_id_o    = irq_pkg::irq_id_t'(3);
    end

    // External
    if (pend_en[11]) begin
      win_valid_o = 1'b1;
      win_id_o    = irq_pkg::irq_id_t'(11);
    end

    // Platform lines, 31 ranks highest
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_en[i]) begin
        win_valid_o = 1'b1;
        win_id_o    = irq_pkg::irq_id_t'(i);
      end
    end
  end

  a_mip_reserved_clear: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mip_o & ~VALID_MASK) == '0
  ) else $error("mip_o has reserved bits set: 0x%08h", mip_o);

endmodule

/* irq_pkg.sv */
/*
  Types of the interrupt side, shared by the arbiter, the acknowledge logic and the top.
  Refer to these as irq_pkg::name.
*/

`include "irq_settings.svh"

package irq_pkg;

  // One bit per interrupt line, also used for mie and mip
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // Interrupt number as reported with the acknowledge
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // Privilege level in RISC-V encoding
  typedef logic [1:0] priv_t;

  localparam priv_t PRIV_M = 2'b11;
  localparam priv_t PRIV_U = 2'b00;

endpackage

/* irq_result.sv */
/*
  Issues the registered interrupt acknowledge and the write-back retire strobe.
  The acknowledge is a single-cycle pulse carrying the winning ID. A waiting
  WFI/WFE retires in any cycle past its first one in which a wake event is seen.
*/

`include "irq_settings.svh"

module irq_result (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             win_valid_i,
  input  irq_pkg::irq_id_t win_id_i,
  input  logic             any_enabled_i,
  input  logic             mstatus_mie_i,
  input  irq_pkg::priv_t   priv_lvl_i,
  input  logic             debug_mode_i,
  input  logic             wfi_in_wb_i,
  input  logic             wfi_first_i,
  input  logic             wake_i,
  output logic             irq_ack_o,
  output irq_pkg::irq_id_t irq_id_o,
  output logic             wb_valid_o
);

  localparam irq_pkg::irq_vec_t VALID_MASK = `IRQ_VALID_MASK;

  logic global_en;
  logic ack_d;

  // M-mode honours mstatus.MIE, U-mode takes any enabled interrupt
  assign global_en = ((priv_lvl_i == irq_pkg::PRIV_M) && mstatus_mie_i) ||
                     ((priv_lvl_i == irq_pkg::PRIV_U) && any_enabled_i);

  // No back-to-back acks, the core needs a cycle to take the trap
  assign ack_d = win_valid_i && global_en && !debug_mode_i && !irq_ack_o;

  // ------------------------------------------------
  // Acknowledge
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_o <= 1'b0;
    end else begin
      irq_ack_o <= ack_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ack_d) irq_id_o <= win_id_i;
  end

  // Retire
  assign wb_valid_o = wfi_in_wb_i && !wfi_first_i && wake_i;

  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o
  ) else $error("irq_ack_o held for more than one cycle");

  a_ack_id_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> VALID_MASK[irq_id_o]
  ) else $error("irq_id_o %0d is a reserved line", irq_id_o);

endmodule

/* irq_settings.svh */
/*
  Shared constants for the interrupt and sleep controller.
  Included by the packages, the RTL blocks that use these values and the testbench.
  SLEEP_DELAY must be at least 2, the write-back residency history is built from it.
*/

`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// Interrupt lines and the subset that is actually wired up
`define IRQ_NUM 32
`define IRQ_VALID_MASK 32'hFFFF_0888
`define IRQ_ID_W 5

// Instruction encodings that request sleep
`define INSTR_WFI 32'h1050_0073
`define INSTR_WFE 32'h8C00_0073

// Cycles a WFI/WFE sits in write-back before sleep is allowed
`define SLEEP_DELAY 2

// Width of the per-bus outstanding transaction counters
`define OUTST_W 4

`endif

/* irq_sleep_top.sv */
/*
  Top level of the interrupt and sleep controller.
  Connects the WFI decoder, the arbiter, the sleep FSM and the result stage.
*/

module irq_sleep_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  irq_pkg::irq_vec_t irq_i,
  input  irq_pkg::irq_vec_t mie_i,
  input  logic              mstatus_mie_i,
  input  logic              mstatus_tw_i,
  input  irq_pkg::priv_t    priv_lvl_i,
  input  logic              debug_mode_i,
  input  logic              debug_req_i,
  input  logic              nmi_pending_i,
  input  logic              wb_instr_valid_i,
  input  sleep_pkg::instr_t wb_instr_i,
  input  logic              wb_instr_err_i,
  input  logic              wb_kill_i,
  input  logic              wake_wfe_i,
  input  logic              ibus_req_i,
  input  logic              ibus_gnt_i,
  input  logic              ibus_rvalid_i,
  input  logic              dbus_req_i,
  input  logic              dbus_gnt_i,
  input  logic              dbus_rvalid_i,
  input  logic              wbuf_busy_i,
  output irq_pkg::irq_vec_t mip_o,
  output logic              irq_ack_o,
  output irq_pkg::irq_id_t  irq_id_o,
  output logic              core_sleep_o,
  output logic              wb_valid_o
);

  logic             wfi_in_wb;
  logic             is_wfe;
  logic             wfi_first;
  logic             wfi_age_ok;
  logic             any_enabled;
  logic             win_valid;
  irq_pkg::irq_id_t win_id;
  logic             wake;

  // ------------------------------------------------
  // Decode and arbitration
  // ------------------------------------------------
  wfi_decode u_wfi_decode (
    .clk_i, .rst_ni, .wb_instr_valid_i, .wb_instr_i, .wb_instr_err_i,
    .wb_kill_i, .debug_mode_i, .mstatus_tw_i, .priv_lvl_i,
    .wfi_in_wb_o  (wfi_in_wb),
    .is_wfe_o     (is_wfe),
    .wfi_first_o  (wfi_first),
    .wfi_age_ok_o (wfi_age_ok)
  );

  irq_arbiter u_irq_arbiter (
    .clk_i, .rst_ni, .irq_i, .mie_i, .mip_o,
    .any_enabled_o (any_enabled),
    .win_valid_o   (win_valid),
    .win_id_o      (win_id)
  );

  // ------------------------------------------------
  // Sleep and result
  // ------------------------------------------------
  sleep_ctrl u_sleep_ctrl (
    .clk_i, .rst_ni,
    .wfi_in_wb_i (wfi_in_wb), .wfi_age_ok_i (wfi_age_ok), .is_wfe_i (is_wfe),
    .any_enabled_i (any_enabled), .debug_req_i, .nmi_pending_i, .wake_wfe_i,
    .ibus_req_i, .ibus_gnt_i, .ibus_rvalid_i, .dbus_req_i, .dbus_gnt_i, .dbus_rvalid_i,
    .wbuf_busy_i, .wake_o (wake), .core_sleep_o
  );

  irq_result u_irq_result (
    .clk_i, .rst_ni,
    .win_valid_i (win_valid), .win_id_i (win_id), .any_enabled_i (any_enabled),
    .mstatus_mie_i, .priv_lvl_i, .debug_mode_i,
    .wfi_in_wb_i (wfi_in_wb), .wfi_first_i (wfi_first), .wake_i (wake),
    .irq_ack_o, .irq_id_o, .wb_valid_o
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_irq_sleep -f sources.f -o sim_irq_sleep

./obj_dir/sim_irq_sleep > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
grep -q '\*\* PASS \*\*' sim.log

/* sleep_ctrl.sv */
/*
  Tracks outstanding bus transactions and runs the sleep state machine.
  A waiting WFI/WFE sleeps once its settle delay has passed and no bus or
  write-buffer activity remains. Any wake event returns the FSM to idle.
*/

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wfi_in_wb_i,
  input  logic wfi_age_ok_i,
  input  logic is_wfe_i,
  input  logic any_enabled_i,
  input  logic debug_req_i,
  input  logic nmi_pending_i,
  input  logic wake_wfe_i,
  input  logic ibus_req_i,
  input  logic ibus_gnt_i,
  input  logic ibus_rvalid_i,
  input  logic dbus_req_i,
  input  logic dbus_gnt_i,
  input  logic dbus_rvalid_i,
  input  logic wbuf_busy_i,
  output logic wake_o,
  output logic core_sleep_o
);

  sleep_pkg::outst_cnt_t   ibus_cnt_q;
  sleep_pkg::outst_cnt_t   dbus_cnt_q;
  logic                    ibus_start;
  logic                    dbus_start;
  logic                    blocked;
  sleep_pkg::sleep_state_e state_q;
  sleep_pkg::sleep_state_e state_d;

  // Starts minus ends, one transaction may start and another end in the same cycle
  function automatic sleep_pkg::outst_cnt_t next_count(input sleep_pkg::outst_cnt_t cnt,
                                                        input logic start,
                                                        input logic done);
    sleep_pkg::outst_cnt_t res;
    res = cnt;
    if (start && !done) begin
      res = cnt + 1'b1;
    end else if (!start && done) begin
      res = cnt - 1'b1;
    end
    return res;
  endfunction

  // ------------------------------------------------
  // Outstanding bus transactions
  // ------------------------------------------------
  assign ibus_start = ibus_req_i && ibus_gnt_i;
  assign dbus_start = dbus_req_i && dbus_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ibus_cnt_q <= '0;
      dbus_cnt_q <= '0;
    end else begin
      ibus_cnt_q <= next_count(ibus_cnt_q, ibus_start, ibus_rvalid_i);
      dbus_cnt_q <= next_count(dbus_cnt_q, dbus_start, dbus_rvalid_i);
    end
  end

  // A transaction starting this cycle also keeps the core awake
  assign blocked = (ibus_cnt_q != '0) || (dbus_cnt_q != '0) ||
                   ibus_start || dbus_start || wbuf_busy_i;

  assign wake_o = any_enabled_i || debug_req_i || nmi_pending_i || (wake_wfe_i && is_wfe_i);

  // ------------------------------------------------
  // Sleep FSM
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      sleep_pkg::SLP_IDLE: begin
        if (wfi_in_wb_i) state_d = sleep_pkg::SLP_WAIT;
      end
      sleep_pkg::SLP_WAIT, sleep_pkg::SLP_BLOCKED: begin
        if (!wfi_in_wb_i || wake_o) begin
          state_d = sleep_pkg::SLP_IDLE;
        end else if (wfi_age_ok_i) begin
          state_d = blocked ? sleep_pkg::SLP_BLOCKED : sleep_pkg::SLP_ASLEEP;
        end
      end
      sleep_pkg::SLP_ASLEEP: begin
        if (!wfi_in_wb_i || wake_o) state_d = sleep_pkg::SLP_IDLE;
      end
      default: state_d = sleep_pkg::SLP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= sleep_pkg::SLP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign core_sleep_o = (state_q == sleep_pkg::SLP_ASLEEP);

  a_sleep_bus_quiet: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> !ibus_rvalid_i && !dbus_rvalid_i && !wbuf_busy_i
  ) else $error("Bus response or busy write buffer while asleep");

  a_sleep_in_wb: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> wfi_in_wb_i
  ) else $error("Asleep without a WFI/WFE in write-back");

  a_ibus_no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ibus_rvalid_i && !ibus_start |-> ibus_cnt_q != '0
  ) else $error("Instruction bus response with nothing outstanding");

  a_dbus_no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dbus_rvalid_i && !dbus_start |-> dbus_cnt_q != '0
  ) else $error("Data bus response with nothing outstanding");

endmodule

/* sleep_pkg.sv */
/*
  Types of the sleep side, shared by the WFI decoder, the sleep controller and the top.
  Refer to these as sleep_pkg::name.
*/

`include "irq_settings.svh"

package sleep_pkg;

  // Write-back instruction word
  typedef logic [31:0] instr_t;

  // Outstanding transactions on one bus
  typedef logic [`OUTST_W-1:0] outst_cnt_t;

  // Sleep controller states
  typedef enum logic [1:0] {
    SLP_IDLE,
    SLP_WAIT,
    SLP_BLOCKED,
    SLP_ASLEEP
  } sleep_state_e;

endpackage

/* sources.f */
+incdir+.
irq_pkg.sv
sleep_pkg.sv
wfi_decode.sv
irq_arbiter.sv
sleep_ctrl.sv
irq_result.sv
irq_sleep_top.sv
tb_irq_sleep.sv

/* tb_irq_sleep.sv */
/*
  Self-checking testbench for the interrupt and sleep controller.
  Concurrent assertions check the DUT, the tests below only drive it.
  Prints one line per test and a closing summary.
*/

`include "irq_settings.svh"

module tb_irq_sleep;

  localparam logic [31:0] MASK = `IRQ_VALID_MASK;

  logic clk_i = 1'b0, rst_ni = 1'b0;
  logic [31:0] irq_i, mie_i, wb_instr_i, mip_o;
  logic mstatus_mie_i, mstatus_tw_i, debug_mode_i, debug_req_i, nmi_pending_i;
  logic [1:0] priv_lvl_i;
  logic wb_instr_valid_i, wb_instr_err_i, wb_kill_i, wake_wfe_i, wbuf_busy_i;
  logic ibus_req_i, ibus_gnt_i, ibus_rvalid_i, dbus_req_i, dbus_gnt_i, dbus_rvalid_i;
  logic irq_ack_o, core_sleep_o, wb_valid_o;
  logic [4:0] irq_id_o;
  logic [31:0] irq_d1, irq_d2, mie_d1;
  int ibus_out, dbus_out, errors, test_errors, tests, acks;
  integer seed = 32'h1188_0daa;

  irq_sleep_top UUT (.*);

  always #10 clk_i = ~clk_i;

  // Reference winner: lines 31 to 16, then 11, 3, 7
  function automatic logic [4:0] priority_winner(input logic [31:0] req);
    for (int i = 31; i >= 16; i--) begin
      if (req[i]) return 5'(i);
    end
    if (req[11]) return 5'd11;
    if (req[3]) return 5'd3;
    return 5'd7;
  endfunction

  // ------------------------------------------------
  // Reference models of the input history
  // ------------------------------------------------
  always @(posedge clk_i) begin
    irq_d1 <= irq_i;
    irq_d2 <= irq_d1;
    mie_d1 <= mie_i;
    if (!rst_ni) begin
      ibus_out <= 0;
      dbus_out <= 0;
    end else begin
      ibus_out <= ibus_out + int'(ibus_req_i && ibus_gnt_i) - int'(ibus_rvalid_i);
      dbus_out <= dbus_out + int'(dbus_req_i && dbus_gnt_i) - int'(dbus_rvalid_i);
    end
  end

  wire is_sleep_op = (wb_instr_i == `INSTR_WFI) || (wb_instr_i == `INSTR_WFE);
  wire wfi_pres = is_sleep_op && wb_instr_valid_i && !wb_instr_err_i && !wb_kill_i &&
                  !debug_mode_i && !(priv_lvl_i == 2'b00 && mstatus_tw_i);
  wire wake_cond = |(irq_d1 & MASK & mie_i) || debug_req_i || nmi_pending_i ||
                   (wake_wfe_i && wb_instr_i == `INSTR_WFE);
  wire blocked_now = ibus_out != 0 || dbus_out != 0 || (ibus_req_i && ibus_gnt_i) ||
                     (dbus_req_i && dbus_gnt_i) || wbuf_busy_i;
  wire quiet = wfi_pres && !blocked_now && !wake_cond;
  wire gate_off = (priv_lvl_i == 2'b11 && !mstatus_mie_i) || debug_mode_i;

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  a_mip: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mip_o == (irq_d1 & MASK)) else begin
    errors++;
    $display("Error at %0t: mip_o got %h expected %h", $time, $sampled(mip_o),
             $sampled(irq_d1) & MASK);
  end

  a_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> irq_id_o == priority_winner(irq_d2 & MASK & mie_d1)) else begin
    errors++;
    $display("Error at %0t: irq_id_o got %0d expected %0d", $time, $sampled(irq_id_o),
             priority_winner($sampled(irq_d2) & MASK & $sampled(mie_d1)));
  end

  a_gate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gate_off |=> !irq_ack_o) else begin
    errors++;
    $display("Error at %0t: irq_ack_o got 1 expected 0 while gated", $time);
  end

  a_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o) else begin
    errors++;
    $display("Error at %0t: irq_ack_o got 1 expected 0 after a pulse", $time);
  end

  // No sleep yet two edges after the WFI is first seen
  a_entry_early: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(wfi_pres, 2) && !$past(wfi_pres, 3) && !$past(wfi_pres, 4) |->
    !core_sleep_o) else begin
    errors++;
    $display("Error at %0t: core_sleep_o got 1 expected 0 before the third edge", $time);
  end

  // WFI first seen at edge k, quiet through k+2, asleep at k+3
  a_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(wfi_pres, 3) && !$past(wfi_pres, 4) && !$past(wfi_pres, 5) &&
    $past(quiet, 3) && $past(quiet, 2) && $past(quiet, 1) |-> core_sleep_o) else begin
    errors++;
    $display("Error at %0t: core_sleep_o got 0 expected 1", $time);
  end

  a_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !core_sleep_o && blocked_now |=> !core_sleep_o) else begin
    errors++;
    $display("Error at %0t: core_sleep_o got 1 expected 0 while blocked", $time);
  end

  a_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o && wake_cond |-> wb_valid_o) else begin
    errors++;
    $display("Error at %0t: wb_valid_o got 0 expected 1 on wake", $time);
  end

  a_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o && wake_cond |=> !core_sleep_o) else begin
    errors++;
    $display("Error at %0t: core_sleep_o got 1 expected 0 after wake", $time);
  end

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------
  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
      if (irq_ack_o) acks++;
    end
  endtask

  task automatic wait_sleep(input logic level, input int limit);
    int cnt;
    cnt = 0;
    while (core_sleep_o !== level) begin
      if (cnt == limit) begin
        $display("Timeout at %0t: core_sleep_o never reached %0b", $time, level);
        $display("** FAIL **");
        $finish;
      end
      step(1);
      cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d %s done, %0d errors", tests, name, errors - test_errors);
    test_errors = errors;
  endtask

  task automatic present(input logic [31:0] instr);
    wb_instr_i = instr;
    wb_instr_valid_i = 1'b1;
  endtask

  // A sleeping core is woken by an NMI before the WFI leaves write-back
  task automatic retract();
    if (core_sleep_o) begin
      nmi_pending_i = 1'b1;
      wait_sleep(1'b0, 4);
      nmi_pending_i = 1'b0;
    end
    wb_instr_valid_i = 1'b0;
    wb_instr_i = '0;
    step(4);
  endtask

  initial begin
    {irq_i, mie_i, wb_instr_i} = '0;
    {mstatus_mie_i, mstatus_tw_i, debug_mode_i, debug_req_i, nmi_pending_i} = '0;
    priv_lvl_i = 2'b11;
    {wb_instr_valid_i, wb_instr_err_i, wb_kill_i, wake_wfe_i, wbuf_busy_i} = '0;
    {ibus_req_i, ibus_gnt_i, ibus_rvalid_i, dbus_req_i, dbus_gnt_i, dbus_rvalid_i} = '0;
    {errors, test_errors, tests, acks} = '0;
    repeat (5) @(posedge clk_i);
    #2 rst_ni = 1'b1;

    for (int i = 0; i < 30; i++) begin
      irq_i = $random(seed);
      step(1);
    end
    finish_test("mip sampling");

    mstatus_mie_i = 1'b1;
    acks = 0;
    for (int i = 0; i < 40; i++) begin
      irq_i = $random(seed);
      mie_i = $random(seed);
      step(3);
    end
    if (acks == 0) begin
      errors++;
      $display("No acknowledge was seen during arbitration");
    end
    finish_test("arbitration");

    // Gated by mstatus.MIE, then by debug mode
    mstatus_mie_i = 1'b0;
    for (int i = 0; i < 20; i++) begin
      irq_i = $random(seed);
      mie_i = $random(seed);
      step(2);
    end
    mstatus_mie_i = 1'b1;
    debug_mode_i = 1'b1;
    for (int i = 0; i < 20; i++) begin
      irq_i = $random(seed);
      step(2);
    end
    debug_mode_i = 1'b0;
    {irq_i, mie_i} = '0;
    step(3);
    finish_test("ack gating");

    present(`INSTR_WFI);
    step(4);
    wait_sleep(1'b1, 2);
    retract();
    finish_test("sleep entry");

    // Instruction bus request left open, then a busy write buffer
    present(`INSTR_WFI);
    {ibus_req_i, ibus_gnt_i} = 2'b11;
    step(1);
    {ibus_req_i, ibus_gnt_i} = 2'b00;
    step(6);
    ibus_rvalid_i = 1'b1;
    step(1);
    ibus_rvalid_i = 1'b0;
    wait_sleep(1'b1, 10);
    retract();
    wbuf_busy_i = 1'b1;
    present(`INSTR_WFI);
    step(6);
    wbuf_busy_i = 1'b0;
    wait_sleep(1'b1, 10);
    retract();
    finish_test("blocking");

    // Wake by interrupt, debug request and WFE event
    mie_i = 32'h0000_0800;
    present(`INSTR_WFI);
    wait_sleep(1'b1, 10);
    irq_i = 32'h0000_0800;
    wait_sleep(1'b0, 10);
    irq_i = '0;
    retract();
    present(`INSTR_WFI);
    wait_sleep(1'b1, 10);
    debug_req_i = 1'b1;
    wait_sleep(1'b0, 10);
    debug_req_i = 1'b0;
    retract();
    present(`INSTR_WFE);
    wait_sleep(1'b1, 10);
    wake_wfe_i = 1'b1;
    wait_sleep(1'b0, 10);
    wake_wfe_i = 1'b0;
    retract();
    finish_test("wake and retire");

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* wfi_decode.sv */
/*
  Qualifies a WFI or WFE sitting in write-back and tracks its residency.
  wfi_first_o marks the first cycle in write-back, wfi_age_ok_o marks that the
  settle delay has passed and sleep may be entered.
*/

`include "irq_settings.svh"

module wfi_decode (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wb_instr_valid_i,
  input  sleep_pkg::instr_t wb_instr_i,
  input  logic              wb_instr_err_i,
  input  logic              wb_kill_i,
  input  logic              debug_mode_i,
  input  logic              mstatus_tw_i,
  input  irq_pkg::priv_t    priv_lvl_i,
  output logic              wfi_in_wb_o,
  output logic              is_wfe_o,
  output logic              wfi_first_o,
  output logic              wfi_age_ok_o
);

  logic                    is_sleep_instr;
  logic                    tw_trap;
  logic [`SLEEP_DELAY-1:0] hist_q;

  // ------------------------------------------------
  // Qualification
  // ------------------------------------------------
  assign is_sleep_instr = (wb_instr_i == `INSTR_WFI) || (wb_instr_i == `INSTR_WFE);

  // U-mode WFI with mstatus.TW set traps instead of sleeping
  assign tw_trap = (priv_lvl_i == irq_pkg::PRIV_U) && mstatus_tw_i;

  assign wfi_in_wb_o = is_sleep_instr && wb_instr_valid_i && !wb_instr_err_i &&
                       !wb_kill_i && !debug_mode_i && !tw_trap;

  assign is_wfe_o = wfi_in_wb_o && (wb_instr_i == `INSTR_WFE);

  // ------------------------------------------------
  // Residency history
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else begin
      hist_q <= {hist_q[`SLEEP_DELAY-2:0], wfi_in_wb_o};
    end
  end

  assign wfi_first_o  = wfi_in_wb_o && !hist_q[0];
  assign wfi_age_ok_o = wfi_in_wb_o && (&hist_q);

  a_age_needs_wb: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wfi_age_ok_o |-> wfi_in_wb_o && $past(wfi_in_wb_o) && $past(wfi_in_wb_o, `SLEEP_DELAY)
  ) else $error("wfi_age_ok_o set before the WFI/WFE settled in write-back");

endmodule
